/* source/memCtrl_cfg.svh */
`ifndef MEM_CTRL_CFG_SVH
`define MEM_CTRL_CFG_SVH

// RAM and request address width
`define MEM_ADDR_W 32

// instruction and data word width
`define WORD_W 32

// RAM data bus, one byte per access
`define BYTE_W 8

// entries per response queue
`define RESP_DEPTH 2

`endif

/* source/memCtrlPkg.sv */
`default_nettype none

`include "memCtrl_cfg.svh"

package memCtrlPkg;

    // number of bytes moved by one access
    typedef enum logic [1:0] {
        LEN_BYTE = 2'd0,
        LEN_HALF = 2'd1,
        LEN_WORD = 2'd2
    } accessLenT;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
    } fetchReqT;

    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic                   isStore;
        accessLenT              len;
        logic [`WORD_W-1:0]     wdata;
    } dataReqT;

    // fetches are always LEN_WORD
    typedef struct packed {
        logic [`MEM_ADDR_W-1:0] addr;
        logic                   isFetch;
        logic                   isStore;
        accessLenT              len;
        logic [`WORD_W-1:0]     wdata;
    } seqCmdT;

    typedef struct packed {
        logic [`WORD_W-1:0] inst;
    } fetchRespT;

    // zero for a store
    typedef struct packed {
        logic [`WORD_W-1:0] rdata;
    } dataRespT;

endpackage

`default_nettype wire

/* source/reqArbiter.sv */
`timescale 1ns/1ns
`default_nettype none

module reqArbiter (
    input  wire                     clk,
    input  wire                     rst,

    input  wire                     i_fetchValid,
    input  wire memCtrlPkg::fetchReqT i_fetchReq,
    output logic                    o_fetchReady,

    input  wire                     i_dataValid,
    input  wire memCtrlPkg::dataReqT  i_dataReq,
    output logic                    o_dataReady,

    output logic                    o_cmdValid,
    output memCtrlPkg::seqCmdT      o_cmd,
    input  wire                     i_cmdReady
);
    import memCtrlPkg::*;

    logic slotFree;
    logic takeData;
    logic takeFetch;

    // register is free if empty or drained this cycle
    assign slotFree = !o_cmdValid || i_cmdReady;

    assign o_dataReady = slotFree;
    // data port wins, fetch backs off whenever data is asking
    assign o_fetchReady = slotFree && !i_dataValid;

    assign takeData = i_dataValid && o_dataReady;
    assign takeFetch = i_fetchValid && o_fetchReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            o_cmdValid <= 1'b0;
        end else if (takeData || takeFetch) begin
            o_cmdValid <= 1'b1;
        end else if (i_cmdReady) begin
            o_cmdValid <= 1'b0;
        end
    end

    // winner becomes a sequencer command
    always_ff @(posedge clk) begin
        if (takeData) begin
            o_cmd.addr    <= i_dataReq.addr;
            o_cmd.isFetch <= 1'b0;
            o_cmd.isStore <= i_dataReq.isStore;
            o_cmd.len     <= i_dataReq.len;
            o_cmd.wdata   <= i_dataReq.wdata;
        end else if (takeFetch) begin
            o_cmd.addr    <= i_fetchReq.addr;
            o_cmd.isFetch <= 1'b1;
            o_cmd.isStore <= 1'b0;
            o_cmd.len     <= LEN_WORD;
            o_cmd.wdata   <= '0;
        end
    end

endmodule

`default_nettype wire

/* source/byteSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "memCtrl_cfg.svh"

module byteSequencer (
    input  wire                       clk,
    input  wire                       rst,

    input  wire                       i_cmdValid,
    input  wire memCtrlPkg::seqCmdT   i_cmd,
    output logic                      o_cmdReady,

    input  wire                       i_pause,

    input  wire [`BYTE_W-1:0]         i_memRdata,
    output logic [`MEM_ADDR_W-1:0]    o_memAddr,
    output logic                      o_memWe,
    output logic [`BYTE_W-1:0]        o_memWdata,

    output logic                      o_fetchPushValid,
    output memCtrlPkg::fetchRespT     o_fetchPush,
    input  wire                       i_fetchPushReady,

    output logic                      o_dataPushValid,
    output memCtrlPkg::dataRespT      o_dataPush,
    input  wire                       i_dataPushReady
);
    import memCtrlPkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ACCESS,
        S_PUSH
    } seqStateT;

    seqStateT           state;
    seqCmdT             cur;
    logic [2:0]         issueCnt;
    logic [2:0]         nBytes;
    logic [1:0]         capIdx;
    logic               capPend;
    logic [`WORD_W-1:0] word;
    logic               active;
    logic               issuing;
    logic               lastWrite;
    logic               pushDone;

    assign active = !i_pause;

    always_comb begin
        case (cur.len)
            LEN_BYTE: nBytes = 3'd1;
            LEN_HALF: nBytes = 3'd2;
            default:  nBytes = 3'd4;
        endcase
    end

    // still bytes left to put on the bus
    assign issuing = (state == S_ACCESS) && (issueCnt != nBytes);
    assign lastWrite = issuing && cur.isStore && (issueCnt == nBytes - 3'd1);

    assign o_cmdReady = (state == S_IDLE) && active;

    assign o_memAddr = cur.addr + {{(`MEM_ADDR_W - 3){1'b0}}, issueCnt};
    assign o_memWdata = cur.wdata[issueCnt[1:0] * `BYTE_W +: `BYTE_W];
    assign o_memWe = issuing && cur.isStore && active;

    // finished word goes to the port that asked for it
    assign o_fetchPushValid = (state == S_PUSH) && cur.isFetch && active;
    assign o_dataPushValid = (state == S_PUSH) && !cur.isFetch && active;
    assign o_fetchPush.inst = word;
    assign o_dataPush.rdata = word;

    assign pushDone = (o_fetchPushValid && i_fetchPushReady)
                   || (o_dataPushValid && i_dataPushReady);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= S_IDLE;
            issueCnt <= '0;
            capPend  <= 1'b0;
        end else begin
            // a read address on the bus now returns data next cycle,
            // even if that address is only being held by a pause
            capPend <= issuing && !cur.isStore;
            if (active) begin
                case (state)
                    S_IDLE: begin
                        if (i_cmdValid) begin
                            state    <= S_ACCESS;
                            issueCnt <= '0;
                        end
                    end
                    S_ACCESS: begin
                        if (issuing) begin
                            issueCnt <= issueCnt + 3'd1;
                        end
                        // stores end on their last write, reads one cycle after the last address
                        if (lastWrite || !issuing) begin
                            state <= S_PUSH;
                        end
                    end
                    S_PUSH: begin
                        if (pushDone) begin
                            state <= S_IDLE;
                        end
                    end
                    default: begin
                        state <= S_IDLE;
                    end
                endcase
            end
        end
    end

    // byte lane of the data now on i_memRdata
    always_ff @(posedge clk) begin
        capIdx <= issueCnt[1:0];
    end

    always_ff @(posedge clk) begin
        if (o_cmdReady && i_cmdValid) begin
            cur  <= i_cmd;
            word <= '0;
        end else if (capPend) begin
            word[capIdx * `BYTE_W +: `BYTE_W] <= i_memRdata;
        end
    end

endmodule

`default_nettype wire

/* source/respBuffer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "memCtrl_cfg.svh"

module respBuffer #(
    parameter type payloadT = logic [`WORD_W-1:0]
) (
    input  wire          clk,
    input  wire          rst,

    input  wire          i_pushValid,
    input  wire payloadT i_push,
    output logic         o_pushReady,

    output logic         o_popValid,
    output payloadT      o_pop,
    input  wire          i_popReady
);
    localparam int DEPTH = `RESP_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payloadT          entries [DEPTH];
    logic [PTR_W-1:0] wrPtr;
    logic [PTR_W-1:0] rdPtr;
    logic [CNT_W-1:0] count;
    logic             doPush;
    logic             doPop;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign o_pushReady = (count != CNT_W'(DEPTH));
    assign o_popValid = (count != '0);
    // oldest entry is always at the read pointer
    assign o_pop = entries[rdPtr];

    assign doPush = i_pushValid && o_pushReady;
    assign doPop = o_popValid && i_popReady;

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (doPop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({doPush, doPop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= i_push;
        end
    end

endmodule

`default_nettype wire

/* source/memCtrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "memCtrl_cfg.svh"

module memCtrl (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        i_rdy,
    input  wire                        i_ioBufferFull,

    // instruction fetch port
    input  wire                        i_fetchValid,
    input  wire memCtrlPkg::fetchReqT  i_fetchReq,
    output logic                       o_fetchReady,
    output logic                       o_fetchRespValid,
    output memCtrlPkg::fetchRespT      o_fetchResp,
    input  wire                        i_fetchRespReady,

    // load/store port
    input  wire                        i_dataValid,
    input  wire memCtrlPkg::dataReqT   i_dataReq,
    output logic                       o_dataReady,
    output logic                       o_dataRespValid,
    output memCtrlPkg::dataRespT       o_dataResp,
    input  wire                        i_dataRespReady,

    // byte-wide RAM
    input  wire [`BYTE_W-1:0]          i_memRdata,
    output logic [`MEM_ADDR_W-1:0]     o_memAddr,
    output logic                       o_memWe,
    output logic [`BYTE_W-1:0]         o_memWdata
);
    import memCtrlPkg::*;

    logic      pause;
    logic      cmdValid;
    seqCmdT    cmd;
    logic      cmdReady;
    logic      fetchPushValid;
    fetchRespT fetchPush;
    logic      fetchPushReady;
    logic      dataPushValid;
    dataRespT  dataPush;
    logic      dataPushReady;

    // stall everything when the core is not ready or IO is backed up
    assign pause = !i_rdy || i_ioBufferFull;

    reqArbiter arbiter_i (
        .clk          (clk),
        .rst          (rst),
        .i_fetchValid (i_fetchValid),
        .i_fetchReq   (i_fetchReq),
        .o_fetchReady (o_fetchReady),
        .i_dataValid  (i_dataValid),
        .i_dataReq    (i_dataReq),
        .o_dataReady  (o_dataReady),
        .o_cmdValid   (cmdValid),
        .o_cmd        (cmd),
        .i_cmdReady   (cmdReady)
    );

    byteSequencer sequencer_i (
        .clk              (clk),
        .rst              (rst),
        .i_cmdValid       (cmdValid),
        .i_cmd            (cmd),
        .o_cmdReady       (cmdReady),
        .i_pause          (pause),
        .i_memRdata       (i_memRdata),
        .o_memAddr        (o_memAddr),
        .o_memWe          (o_memWe),
        .o_memWdata       (o_memWdata),
        .o_fetchPushValid (fetchPushValid),
        .o_fetchPush      (fetchPush),
        .i_fetchPushReady (fetchPushReady),
        .o_dataPushValid  (dataPushValid),
        .o_dataPush       (dataPush),
        .i_dataPushReady  (dataPushReady)
    );

    respBuffer #(
        .payloadT (fetchRespT)
    ) fetchBuf_i (
        .clk         (clk),
        .rst         (rst),
        .i_pushValid (fetchPushValid),
        .i_push      (fetchPush),
        .o_pushReady (fetchPushReady),
        .o_popValid  (o_fetchRespValid),
        .o_pop       (o_fetchResp),
        .i_popReady  (i_fetchRespReady)
    );

    respBuffer #(
        .payloadT (dataRespT)
    ) dataBuf_i (
        .clk         (clk),
        .rst         (rst),
        .i_pushValid (dataPushValid),
        .i_push      (dataPush),
        .o_pushReady (dataPushReady),
        .o_popValid  (o_dataRespValid),
        .o_pop       (o_dataResp),
        .i_popReady  (i_dataRespReady)
    );

endmodule

`default_nettype wire

/* verification/clkGen.sv */
`timescale 1ns/1ns
`default_nettype none

module clkGen #(
    parameter int PERIOD_NS = 40
) (
    output logic o_clk
);
    initial begin
        o_clk = 1'b0;
    end

    always #(PERIOD_NS / 2) o_clk = ~o_clk;

endmodule

`default_nettype wire

/* verification/ramModel.sv */
`timescale 1ns/1ns
`default_nettype none

`include "memCtrl_cfg.svh"

module ramModel #(
    parameter int ADDR_BITS = 8
) (
    input  wire                    clk,
    input  wire [`MEM_ADDR_W-1:0]  i_addr,
    input  wire                    i_we,
    input  wire [`BYTE_W-1:0]      i_wdata,
    output logic [`BYTE_W-1:0]     o_rdata
);
    // upper address bits of the small RAM wrap
    logic [`BYTE_W-1:0] mem [2**ADDR_BITS];

    // read data shows up one clock after the address
    always @(posedge clk) begin
        o_rdata <= mem[i_addr[ADDR_BITS-1:0]];
        if (i_we) begin
            mem[i_addr[ADDR_BITS-1:0]] <= i_wdata;
        end
    end

endmodule

`default_nettype wire

/* verification/memCtrlTb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "memCtrl_cfg.svh"

module memCtrlTb;
    import memCtrlPkg::*;

    localparam int TIMEOUT = 400;

    wire                    clk;
    logic                   rst;
    logic                   i_rdy;
    logic                   i_ioBufferFull;
    logic                   i_fetchValid;
    fetchReqT               i_fetchReq;
    logic                   o_fetchReady;
    logic                   o_fetchRespValid;
    fetchRespT              o_fetchResp;
    logic                   i_fetchRespReady;
    logic                   i_dataValid;
    dataReqT                i_dataReq;
    logic                   o_dataReady;
    logic                   o_dataRespValid;
    dataRespT               o_dataResp;
    logic                   i_dataRespReady;
    wire [`BYTE_W-1:0]      i_memRdata;
    logic [`MEM_ADDR_W-1:0] o_memAddr;
    logic                   o_memWe;
    logic [`BYTE_W-1:0]     o_memWdata;

    integer             seed = 46650;
    logic [7:0]         mirror [256];
    logic [1:0]         pausePat [256];
    logic [7:0]         patIdx = '0;
    logic               shakePause = 1'b0;
    logic [`WORD_W-1:0] fetchGot [$];
    logic [`WORD_W-1:0] dataGot [$];
    time                lastFetchAt;
    time                lastDataAt;

    clkGen #(.PERIOD_NS(40)) clkGen_i (.o_clk(clk));

    ramModel ram_i (
        .clk     (clk),
        .i_addr  (o_memAddr),
        .i_we    (o_memWe),
        .i_wdata (o_memWdata),
        .o_rdata (i_memRdata)
    );

    memCtrl memCtrl_i (.*);

    task automatic abortRun();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic failWith(input string what);
        $display("ERROR: %s", what);
        abortRun();
    endtask

    task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
            else begin
                $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
                abortRun();
            end
    endtask

    // little-endian bytes from the mirror, zero-extended
    function automatic logic [`WORD_W-1:0] expectedRead(input logic [7:0] addr, input int nBytes);
        logic [`WORD_W-1:0] word;
        word = '0;
        for (int k = 0; k < nBytes; k++) begin
            word[8*k +: 8] = mirror[addr + 8'(k)];
        end
        return word;
    endfunction

    function automatic int byteCount(input accessLenT len);
        case (len)
            LEN_BYTE: return 1;
            LEN_HALF: return 2;
            default:  return 4;
        endcase
    endfunction

    // keep the fetch valid until taken or out of cycles
    task automatic holdFetch(input int maxCycles, output bit taken);
        taken = 1'b0;
        for (int t = 0; t < maxCycles && !taken; t++) begin
            @(posedge clk);
            taken = o_fetchReady;
        end
        if (taken) begin
            @(negedge clk);
            i_fetchValid = 1'b0;
        end
    endtask

    task automatic offerFetch(input logic [31:0] addr, input int maxCycles, output bit taken);
        @(negedge clk);
        i_fetchValid = 1'b1;
        i_fetchReq.addr = addr;
        holdFetch(maxCycles, taken);
    endtask

    task automatic requireTaken(input bit taken);
        if (!taken) begin
            failWith("fetch request was never accepted");
        end
    endtask

    task automatic sendData(input logic [31:0] addr, input bit isStore, input accessLenT len,
                            input logic [31:0] wdata);
        bit taken;
        @(negedge clk);
        i_dataValid = 1'b1;
        i_dataReq.addr = addr;
        i_dataReq.isStore = isStore;
        i_dataReq.len = len;
        i_dataReq.wdata = wdata;
        taken = 1'b0;
        for (int t = 0; t < TIMEOUT && !taken; t++) begin
            @(posedge clk);
            taken = o_dataReady;
        end
        if (!taken) begin
            failWith("data request was never accepted");
        end else begin
            @(negedge clk);
            i_dataValid = 1'b0;
        end
    endtask

    task automatic expectFetch(input logic [31:0] exp);
        for (int t = 0; t < TIMEOUT && fetchGot.size() == 0; t++) begin
            @(posedge clk);
        end
        if (fetchGot.size() == 0) begin
            failWith("no fetch response arrived");
        end else begin
            checkValue("o_fetchResp.inst", fetchGot.pop_front(), exp);
        end
    endtask

    task automatic expectData(input logic [31:0] exp);
        for (int t = 0; t < TIMEOUT && dataGot.size() == 0; t++) begin
            @(posedge clk);
        end
        if (dataGot.size() == 0) begin
            failWith("no data response arrived");
        end else begin
            checkValue("o_dataResp.rdata", dataGot.pop_front(), exp);
        end
    endtask

    // random stalls only while shaking
    always @(negedge clk) begin
        i_rdy = !shakePause || (pausePat[patIdx] != 2'd0);
        i_ioBufferFull = shakePause && (pausePat[patIdx] == 2'd3);
        patIdx = patIdx + 8'd1;
    end

    always @(posedge clk) begin
        if (!rst) begin
            if (!i_rdy || i_ioBufferFull) begin
                checkValue("o_memWe", o_memWe, 1'b0);
            end
            if (o_fetchRespValid && i_fetchRespReady) begin
                fetchGot.push_back(o_fetchResp.inst);
                lastFetchAt = $time;
            end
            if (o_dataRespValid && i_dataRespReady) begin
                dataGot.push_back(o_dataResp.rdata);
                lastDataAt = $time;
            end
        end
    end

    initial begin
        logic [31:0] addr;
        logic [31:0] dataAddr;
        logic [31:0] wdata;
        logic [31:0] fetchAddrs [$];
        bit          taken;
        int          accepted;
        accessLenT   len;

        rst = 1'b1;
        i_rdy = 1'b1;
        i_ioBufferFull = 1'b0;
        i_fetchValid = 1'b0;
        i_fetchReq = '0;
        i_fetchRespReady = 1'b1;
        i_dataValid = 1'b0;
        i_dataReq = '0;
        i_dataRespReady = 1'b1;
        for (int a = 0; a < 256; a++) begin
            mirror[a] = 8'($random(seed));
            ram_i.mem[a] = mirror[a];
            pausePat[a] = 2'($random(seed));
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        @(posedge clk);
        checkValue("o_fetchRespValid", o_fetchRespValid, 1'b0);
        checkValue("o_dataRespValid", o_dataRespValid, 1'b0);
        checkValue("o_memWe", o_memWe, 1'b0);
        checkValue("o_fetchReady", o_fetchReady, 1'b1);
        checkValue("o_dataReady", o_dataReady, 1'b1);

        addr = $random(seed);
        offerFetch(addr, TIMEOUT, taken);
        requireTaken(taken);
        expectFetch(expectedRead(addr[7:0], 4));

        for (int l = 0; l < 3; l++) begin
            len = accessLenT'(l);
            addr = $random(seed);
            sendData(addr, 1'b0, len, '0);
            expectData(expectedRead(addr[7:0], byteCount(len)));
        end

        // stores under random stalls, read back as whole words
        shakePause = 1'b1;
        for (int l = 0; l < 3; l++) begin
            len = accessLenT'(l);
            addr = $random(seed);
            wdata = $random(seed);
            sendData(addr, 1'b1, len, wdata);
            expectData('0);
            for (int k = 0; k < byteCount(len); k++) begin
                mirror[addr[7:0] + 8'(k)] = wdata[8*k +: 8];
            end
            sendData(addr, 1'b0, LEN_WORD, '0);
            expectData(expectedRead(addr[7:0], 4));
        end
        addr = $random(seed);
        offerFetch(addr, TIMEOUT, taken);
        requireTaken(taken);
        expectFetch(expectedRead(addr[7:0], 4));
        shakePause = 1'b0;

        // both ports in one cycle
        @(negedge clk);
        addr = $random(seed);
        dataAddr = $random(seed);
        i_fetchValid = 1'b1;
        i_fetchReq.addr = addr;
        i_dataValid = 1'b1;
        i_dataReq.addr = dataAddr;
        i_dataReq.isStore = 1'b0;
        i_dataReq.len = LEN_WORD;
        @(posedge clk);
        checkValue("o_fetchReady", o_fetchReady, 1'b0);
        checkValue("o_dataReady", o_dataReady, 1'b1);
        @(negedge clk);
        i_dataValid = 1'b0;
        holdFetch(TIMEOUT, taken);
        requireTaken(taken);
        expectData(expectedRead(dataAddr[7:0], 4));
        expectFetch(expectedRead(addr[7:0], 4));
        assert (lastDataAt < lastFetchAt)
            else failWith("fetch response arrived before the data response");

        // back-pressure on fetch responses until the port stalls
        @(negedge clk);
        i_fetchRespReady = 1'b0;
        accepted = 0;
        taken = 1'b1;
        while (taken && accepted < 8) begin
            addr = $random(seed);
            fetchAddrs.push_back(addr);
            offerFetch(addr, 30, taken);
            if (taken) begin
                accepted++;
            end
        end
        assert (!taken && accepted <= 4)
            else failWith("fetch port kept accepting with responses held back");
        for (int t = 0; t < 20; t++) begin
            @(posedge clk);
            checkValue("o_fetchReady", o_fetchReady, 1'b0);
        end
        @(negedge clk);
        i_fetchRespReady = 1'b1;
        holdFetch(TIMEOUT, taken);
        requireTaken(taken);
        foreach (fetchAddrs[i]) begin
            expectFetch(expectedRead(fetchAddrs[i][7:0], 4));
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+source
source/memCtrlPkg.sv
source/reqArbiter.sv
source/byteSequencer.sv
source/respBuffer.sv
source/memCtrl.sv
verification/clkGen.sv
verification/ramModel.sv
verification/memCtrlTb.sv

/* Bender.yml */
package:
  name: memctrl

sources:
  - include_dirs:
      - source
    files:
      - source/memCtrlPkg.sv
      - source/reqArbiter.sv
      - source/byteSequencer.sv
      - source/respBuffer.sv
      - source/memCtrl.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/clkGen.sv
      - verification/ramModel.sv
      - verification/memCtrlTb.sv
